/* Makefile */
# Verilator flow for the ALU testbench

TOP       ?= alu_tb
VERILATOR ?= verilator
VFLAGS    ?= --assert --timing --timescale 1ns/100ps -Wno-fatal
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
PASS_TEXT := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the simulation, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: TOP VERILATOR VFLAGS FILELIST OBJDIR"

test:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

/* bench/alu_props.sv */
module alu_props (
    input logic                           clock,
    input logic                           reset,
    input logic                           z_in,
    input logic                           inc_pc,
    input logic [alu_pkg::data_width-1:0] z_hi,
    input logic [alu_pkg::data_width-1:0] z_lo
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Z pair keeps its value while the strobe is low
    z_holds_without_strobe: assert property (
        @(posedge clock) disable iff (reset)
        !z_in |=> ($stable(z_hi) && $stable(z_lo))
    ) else begin
        $error("Z pair changed while z_in was low");
        fail_count++;
    end

    z_zero_after_reset: assert property (
        @(posedge clock)
        reset |=> (z_hi == '0 && z_lo == '0)
    ) else begin
        $error("Z pair not zero after reset");
        fail_count++;
    end

    // PC increment only ever fills the low word
    z_hi_zero_on_inc_pc: assert property (
        @(posedge clock) disable iff (reset)
        (z_in && inc_pc) |=> (z_hi == '0)
    ) else begin
        $error("Upper Z word not zero after a PC increment");
        fail_count++;
    end

endmodule

/* bench/alu_tb.sv */
module alu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int random_rows  = 200;
    localparam int clock_period = 4;

    typedef struct packed {
        logic [4:0]  op;
        logic        inc_pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_hi;
        logic [31:0] exp_lo;
    } row_t;

    logic                           clock;
    logic                           reset;
    logic [alu_pkg::data_width-1:0] a;
    logic [alu_pkg::data_width-1:0] b;
    alu_pkg::alu_op_e               op;
    logic                           inc_pc;
    logic                           z_in;
    logic [alu_pkg::data_width-1:0] z_hi;
    logic [alu_pkg::data_width-1:0] z_lo;

    row_t        vectors[$];
    int          error_count;
    int          check_count;
    logic [31:0] lfsr_state;
    bit          table_ready;

    alu u_dut (
        .clock  (clock),
        .reset  (reset),
        .a      (a),
        .b      (b),
        .op     (op),
        .inc_pc (inc_pc),
        .z_in   (z_in),
        .z_hi   (z_hi),
        .z_lo   (z_lo)
    );

    bind alu_result_select alu_props u_props (
        .clock  (clock),
        .reset  (reset),
        .z_in   (z_in),
        .inc_pc (inc_pc),
        .z_hi   (z_hi),
        .z_lo   (z_lo)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Outputs have settled by the time inputs change half a nanosecond after the edge
    task automatic next_cycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %0.1f ns %s: got %h, expected %h", $realtime, name, got, expected);
        end
    endtask

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [4:0] pick_opcode(input logic [3:0] index);
        case (index)
            4'd0:  return alu_pkg::op_add;
            4'd1:  return alu_pkg::op_sub;
            4'd2:  return alu_pkg::op_shr;
            4'd3:  return alu_pkg::op_shra;
            4'd4:  return alu_pkg::op_shl;
            4'd5:  return alu_pkg::op_ror;
            4'd6:  return alu_pkg::op_rol;
            4'd7:  return alu_pkg::op_or;
            4'd8:  return alu_pkg::op_and;
            4'd9:  return alu_pkg::op_mul;
            4'd10: return alu_pkg::op_div;
            4'd11: return alu_pkg::op_neg;
            4'd12: return alu_pkg::op_not;
            4'd13: return alu_pkg::op_uadd;
            4'd14: return 5'b00000; // Undefined codes
            default: return 5'b01100;
        endcase
    endfunction

    // Reference model with the hi word in the upper half
    function automatic logic [63:0] expected_result(input logic [4:0] code,
                                                    input logic inc_level,
                                                    input logic [31:0] x,
                                                    input logic [31:0] y);
        int          amount;
        longint      sx;
        longint      sy;
        logic [31:0] word;
        logic [63:0] wide;
        amount = int'(y[4:0]);
        sx     = longint'($signed(x));
        sy     = longint'($signed(y));
        word   = '0;
        wide   = '0;
        if (inc_level) begin
            return {32'h0, y + 32'd1};
        end
        case (code)
            alu_pkg::op_and:  word = x & y;
            alu_pkg::op_or:   word = x | y;
            alu_pkg::op_not:  word = ~y;
            alu_pkg::op_neg:  word = -y;
            alu_pkg::op_shl:  word = x << amount;
            alu_pkg::op_shr:  word = x >> amount;
            alu_pkg::op_shra: word = $signed(x) >>> amount;
            alu_pkg::op_rol:  word = (x << amount) | (x >> (32 - amount));
            alu_pkg::op_ror:  word = (x >> amount) | (x << (32 - amount));
            alu_pkg::op_add:  word = x + y;
            alu_pkg::op_sub:  word = x - y;
            alu_pkg::op_uadd: wide = {31'h0, {1'b0, x} + {1'b0, y}};
            alu_pkg::op_mul:  wide = sx * sy;
            alu_pkg::op_div: begin
                if (y == 32'h0) begin
                    wide = {x, 32'hFFFF_FFFF};
                end else begin
                    wide = {32'(sx % sy), 32'(sx / sy)}; // Remainder keeps the sign of x
                end
            end
            default: word = '0;
        endcase
        return wide | {32'h0, word};
    endfunction

    task automatic add_row(input logic [4:0] code, input logic inc_level,
                           input logic [31:0] x, input logic [31:0] y,
                           input logic [31:0] hi, input logic [31:0] lo);
        row_t row;
        row = {code, inc_level, x, y, hi, lo};
        vectors.push_back(row);
    endtask

    task automatic load_table();
        add_row(alu_pkg::op_and, 1'b0, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 32'h00F0_1200);
        add_row(alu_pkg::op_or, 1'b0, 32'hF000_000F, 32'h0000_F0F0, 32'h0, 32'hF000_F0FF);
        add_row(alu_pkg::op_not, 1'b0, 32'h1234_5678, 32'h0000_FFFF, 32'h0, 32'hFFFF_0000);
        add_row(alu_pkg::op_neg, 1'b0, 32'h0, 32'h1, 32'h0, 32'hFFFF_FFFF);
        add_row(alu_pkg::op_neg, 1'b0, 32'h0, 32'h8000_0000, 32'h0, 32'h8000_0000);
        add_row(alu_pkg::op_shl, 1'b0, 32'h8000_0001, 32'h1, 32'h0, 32'h2);
        add_row(alu_pkg::op_shl, 1'b0, 32'hDEAD_BEEF, 32'h20, 32'h0, 32'hDEAD_BEEF); // Amount 0
        add_row(alu_pkg::op_shl, 1'b0, 32'h3, 32'h1F, 32'h0, 32'h8000_0000);
        add_row(alu_pkg::op_shr, 1'b0, 32'h8000_00F0, 32'h4, 32'h0, 32'h0800_000F);
        add_row(alu_pkg::op_shr, 1'b0, 32'h8000_0000, 32'h1F, 32'h0, 32'h1);
        add_row(alu_pkg::op_shra, 1'b0, 32'h8000_00F0, 32'h4, 32'h0, 32'hF800_000F);
        add_row(alu_pkg::op_shra, 1'b0, 32'h8000_0000, 32'h1F, 32'h0, 32'hFFFF_FFFF);
        add_row(alu_pkg::op_rol, 1'b0, 32'h1234_5678, 32'h4, 32'h0, 32'h2345_6781);
        add_row(alu_pkg::op_rol, 1'b0, 32'h8000_0001, 32'h1F, 32'h0, 32'hC000_0000);
        add_row(alu_pkg::op_ror, 1'b0, 32'h1234_5678, 32'h8, 32'h0, 32'h7812_3456);
        add_row(alu_pkg::op_ror, 1'b0, 32'hCAFE_F00D, 32'h0, 32'h0, 32'hCAFE_F00D);
        add_row(alu_pkg::op_add, 1'b0, 32'h5, 32'hFFFF_FFFD, 32'h0, 32'h2);
        add_row(alu_pkg::op_add, 1'b0, 32'h7FFF_FFFF, 32'h1, 32'h0, 32'h8000_0000);
        add_row(alu_pkg::op_sub, 1'b0, 32'h3, 32'h5, 32'h0, 32'hFFFF_FFFE);
        add_row(alu_pkg::op_sub, 1'b0, 32'h8000_0000, 32'h1, 32'h0, 32'h7FFF_FFFF);
        add_row(alu_pkg::op_uadd, 1'b0, 32'hFFFF_FFFF, 32'h1, 32'h1, 32'h0);
        add_row(alu_pkg::op_uadd, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h1, 32'hFFFF_FFFE);
        add_row(5'b00000, 1'b0, 32'h1234, 32'h5678, 32'h0, 32'h0);
        add_row(5'b11110, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0);
        add_row(alu_pkg::op_mul, 1'b0, 32'h3, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 32'hFFFF_FFFA);
        add_row(alu_pkg::op_mul, 1'b0, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 32'h0);
        add_row(alu_pkg::op_mul, 1'b0, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF, 32'h1);
        add_row(alu_pkg::op_mul, 1'b0, 32'h8000_0000, 32'h7FFF_FFFF, 32'hC000_0000, 32'h8000_0000);
        add_row(alu_pkg::op_mul, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h1);
        add_row(alu_pkg::op_div, 1'b0, 32'h7, 32'h2, 32'h1, 32'h3);
        add_row(alu_pkg::op_div, 1'b0, 32'hFFFF_FFF9, 32'h2, 32'hFFFF_FFFF, 32'hFFFF_FFFD);
        add_row(alu_pkg::op_div, 1'b0, 32'h7, 32'hFFFF_FFFE, 32'h1, 32'hFFFF_FFFD);
        add_row(alu_pkg::op_div, 1'b0, 32'hFFFF_FFF9, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 32'h3);
        add_row(alu_pkg::op_div, 1'b0, 32'h1234_5678, 32'h0, 32'h1234_5678, 32'hFFFF_FFFF);
        add_row(alu_pkg::op_div, 1'b0, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h8000_0000);
        add_row(alu_pkg::op_mul, 1'b1, 32'hDEAD_BEEF, 32'h0000_0FFF, 32'h0, 32'h1000);
        add_row(alu_pkg::op_div, 1'b1, 32'h5, 32'hFFFF_FFFF, 32'h0, 32'h0);
        add_row(5'b00000, 1'b1, 32'h0, 32'h1234_5678, 32'h0, 32'h1234_5679);
    endtask

    task automatic apply_row(input row_t row);
        a      = row.a;
        b      = row.b;
        op     = alu_pkg::alu_op_e'(row.op);
        inc_pc = row.inc_pc;
        z_in   = 1'b1;
        next_cycle();
        check_value("z_hi", z_hi, row.exp_hi);
        check_value("z_lo", z_lo, row.exp_lo);
    endtask

    task automatic make_random_row(output row_t row);
        logic [31:0] bits;
        logic [63:0] expected;
        draw_bits(4, bits);
        row.op = pick_opcode(bits[3:0]);
        draw_bits(3, bits);
        row.inc_pc = (bits[2:0] == 3'b000); // About one row in eight
        draw_bits(32, bits);
        row.a = bits;
        draw_bits(32, bits);
        row.b    = bits;
        expected = expected_result(row.op, row.inc_pc, row.a, row.b);
        row.exp_hi = expected[63:32];
        row.exp_lo = expected[31:0];
    endtask

    // Load a known value and then keep changing operands with the strobe low
    task automatic check_hold();
        a      = 32'h0000_00F0;
        b      = 32'h0F00_0000;
        op     = alu_pkg::op_or;
        inc_pc = 1'b0;
        z_in   = 1'b1;
        next_cycle();
        check_value("z_hi", z_hi, 32'h0);
        check_value("z_lo", z_lo, 32'h0F00_00F0);
        z_in = 1'b0;
        for (int k = 0; k < 4; k++) begin
            a      = ~a;
            b      = b + 32'h1234_5678;
            op     = k[0] ? alu_pkg::op_mul : alu_pkg::op_div;
            inc_pc = k[1];
            next_cycle();
            check_value("z_hi", z_hi, 32'h0);
            check_value("z_lo", z_lo, 32'h0F00_00F0);
        end
    endtask

    initial begin : main
        row_t row;
        reset       = 1'b1;
        z_in        = 1'b1; // Strobe stays high while reset is held
        inc_pc      = 1'b0;
        op          = alu_pkg::op_not;
        a           = '0;
        b           = '0;
        error_count = 0;
        check_count = 0;
        lfsr_state  = 32'h3a6c;
        load_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clock);
        #0.5;
        reset = 1'b0;
        z_in  = 1'b0;
        check_value("z_hi", z_hi, 32'h0);
        check_value("z_lo", z_lo, 32'h0);
        check_hold();
        foreach (vectors[i]) begin
            apply_row(vectors[i]);
        end
        for (int n = 0; n < random_rows; n++) begin
            make_random_row(row);
            apply_row(row);
        end
        error_count += u_dut.u_result_select.u_props.fail_count;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #((vectors.size() + random_rows + 20) * clock_period * 2);
        $display("Timeout: the run did not finish in the expected time");
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Errors found");
        $finish;
    end

endmodule

/* logic/alu.sv */
module alu (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [alu_pkg::data_width-1:0] a,
    input  logic [alu_pkg::data_width-1:0] b,
    input  alu_pkg::alu_op_e               op,
    input  logic                           inc_pc,
    input  logic                           z_in,
    output logic [alu_pkg::data_width-1:0] z_hi,
    output logic [alu_pkg::data_width-1:0] z_lo
);

    logic [alu_pkg::data_width-1:0]   logic_result;
    logic [alu_pkg::data_width-1:0]   sum_result;
    logic [alu_pkg::data_width-1:0]   diff_result;
    logic [alu_pkg::result_width-1:0] uadd_result;
    logic [alu_pkg::data_width-1:0]   inc_result;
    logic [alu_pkg::result_width-1:0] product;
    logic [alu_pkg::data_width-1:0]   quotient;
    logic [alu_pkg::data_width-1:0]   remainder;

    alu_logic_shift u_logic_shift (
        .a            (a),
        .b            (b),
        .op           (op),
        .logic_result (logic_result)
    );

    alu_arith u_arith (
        .a           (a),
        .b           (b),
        .sum_result  (sum_result),
        .diff_result (diff_result),
        .uadd_result (uadd_result),
        .inc_result  (inc_result),
        .product     (product),
        .quotient    (quotient),
        .remainder   (remainder)
    );

    alu_result_select u_result_select (
        .clock        (clock),
        .reset        (reset),
        .op           (op),
        .inc_pc       (inc_pc),
        .z_in         (z_in),
        .logic_result (logic_result),
        .sum_result   (sum_result),
        .diff_result  (diff_result),
        .uadd_result  (uadd_result),
        .inc_result   (inc_result),
        .product      (product),
        .quotient     (quotient),
        .remainder    (remainder),
        .z_hi         (z_hi),
        .z_lo         (z_lo)
    );

endmodule

/* logic/alu_arith.sv */
module alu_arith (
    input  logic [alu_pkg::data_width-1:0]   a,
    input  logic [alu_pkg::data_width-1:0]   b,
    output logic [alu_pkg::data_width-1:0]   sum_result,
    output logic [alu_pkg::data_width-1:0]   diff_result,
    output logic [alu_pkg::result_width-1:0] uadd_result,
    output logic [alu_pkg::data_width-1:0]   inc_result,
    output logic [alu_pkg::result_width-1:0] product,
    output logic [alu_pkg::data_width-1:0]   quotient,
    output logic [alu_pkg::data_width-1:0]   remainder
);

    logic [alu_pkg::data_width-1:0] b_inv;
    logic [alu_pkg::carry_bit:0]    uadd_sum;

    // Signed add, wraps on overflow
    assign sum_result = a + b;

    // Subtract as a plus inverted b with carry in set
    assign b_inv       = ~b;
    assign diff_result = a + b_inv + 1'b1;

    // Unsigned add keeps its carry one bit above the word
    assign uadd_sum = {1'b0, a} + {1'b0, b};

    always_comb begin
        uadd_result = {alu_pkg::word_zero, alu_pkg::word_zero};
        uadd_result[alu_pkg::carry_bit:0] = uadd_sum;
    end

    // Program counter increment path
    assign inc_result = b + 1'b1;

    booth_multiplier u_booth_multiplier (
        .a       (a),
        .b       (b),
        .product (product)
    );

    restoring_divider u_restoring_divider (
        .a         (a),
        .b         (b),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

/* logic/alu_logic_shift.sv */
module alu_logic_shift (
    input  logic [alu_pkg::data_width-1:0] a,
    input  logic [alu_pkg::data_width-1:0] b,
    input  alu_pkg::alu_op_e               op,
    output logic [alu_pkg::data_width-1:0] logic_result
);

    logic [alu_pkg::shamt_width-1:0]    shamt;
    logic signed [alu_pkg::data_width-1:0] a_signed;

    // Doubled word, so a rotate becomes a plain shift plus a slice
    logic [2*alu_pkg::data_width-1:0] a_twice;
    logic [2*alu_pkg::data_width-1:0] rol_full;
    logic [2*alu_pkg::data_width-1:0] ror_full;

    logic [alu_pkg::data_width-1:0] shl_word;
    logic [alu_pkg::data_width-1:0] shr_word;
    logic [alu_pkg::data_width-1:0] shra_word;
    logic [alu_pkg::data_width-1:0] rol_word;
    logic [alu_pkg::data_width-1:0] ror_word;

    assign shamt    = b[alu_pkg::shamt_width-1:0];
    assign a_signed = a;
    assign a_twice  = {a, a};

    assign shl_word  = a << shamt;
    assign shr_word  = a >> shamt;
    assign shra_word = a_signed >>> shamt; // Sign bit of a fills from the top

    assign rol_full = a_twice << shamt;
    assign ror_full = a_twice >> shamt;

    // Upper half after a left shift holds the bits that wrapped in from the right
    assign rol_word = rol_full[2*alu_pkg::data_width-1:alu_pkg::data_width];
    assign ror_word = ror_full[alu_pkg::data_width-1:0];

    always_comb begin
        case (op)
            alu_pkg::op_and: begin
                logic_result = a & b;
            end
            alu_pkg::op_or: begin
                logic_result = a | b;
            end
            alu_pkg::op_neg: begin
                logic_result = -b; // Two's complement of B
            end
            alu_pkg::op_not: begin
                logic_result = ~b;
            end
            alu_pkg::op_shl: begin
                logic_result = shl_word;
            end
            alu_pkg::op_shr: begin
                logic_result = shr_word;
            end
            alu_pkg::op_shra: begin
                logic_result = shra_word;
            end
            alu_pkg::op_rol: begin
                logic_result = rol_word;
            end
            alu_pkg::op_ror: begin
                logic_result = ror_word;
            end
            default: begin
                // Arithmetic and undefined codes leave this unit silent
                logic_result = alu_pkg::word_zero;
            end
        endcase
    end

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

    // Operand and result widths
    localparam int data_width   = 32;
    localparam int result_width = 2 * data_width;

    // Only the low bits of operand B act as a shift or rotate amount
    localparam int shamt_width  = 5;

    // Radix-4 recoding handles two multiplier bits per digit
    localparam int booth_digits = data_width / 2;

    // Unsigned add carry lands just above the low word
    localparam int carry_bit    = data_width;

    // Zero word for padding the upper half of single-word results
    localparam logic [data_width-1:0] word_zero = '0;

    // Opcodes keep the datapath control encodings
    typedef enum logic [4:0] {
        op_add  = 5'b00011,
        op_sub  = 5'b00100,
        op_shr  = 5'b00101,
        op_shra = 5'b00110,
        op_shl  = 5'b00111,
        op_ror  = 5'b01000,
        op_rol  = 5'b01001,
        op_or   = 5'b01010,
        op_and  = 5'b01011,
        op_mul  = 5'b01111,
        op_div  = 5'b10000,
        op_neg  = 5'b10001,
        op_not  = 5'b10010,
        op_uadd = 5'b11111
    } alu_op_e;

endpackage

/* logic/alu_result_select.sv */
module alu_result_select (
    input  logic                             clock,
    input  logic                             reset,
    input  alu_pkg::alu_op_e                 op,
    input  logic                             inc_pc,
    input  logic                             z_in,
    input  logic [alu_pkg::data_width-1:0]   logic_result,
    input  logic [alu_pkg::data_width-1:0]   sum_result,
    input  logic [alu_pkg::data_width-1:0]   diff_result,
    input  logic [alu_pkg::result_width-1:0] uadd_result,
    input  logic [alu_pkg::data_width-1:0]   inc_result,
    input  logic [alu_pkg::result_width-1:0] product,
    input  logic [alu_pkg::data_width-1:0]   quotient,
    input  logic [alu_pkg::data_width-1:0]   remainder,
    output logic [alu_pkg::data_width-1:0]   z_hi,
    output logic [alu_pkg::data_width-1:0]   z_lo
);

    // One-hot decode of the arithmetic opcodes
    logic sel_add;
    logic sel_sub;
    logic sel_uadd;
    logic sel_mul;
    logic sel_div;

    logic [alu_pkg::result_width-1:0] next_z;

    assign sel_add  = (op == alu_pkg::op_add);
    assign sel_sub  = (op == alu_pkg::op_sub);
    assign sel_uadd = (op == alu_pkg::op_uadd);
    assign sel_mul  = (op == alu_pkg::op_mul);
    assign sel_div  = (op == alu_pkg::op_div);

    // Logic unit is already zero outside its own opcodes
    always_comb begin
        if (inc_pc) begin
            next_z = {alu_pkg::word_zero, inc_result}; // PC increment wins
        end else begin
            next_z = {alu_pkg::word_zero, logic_result}
                   | ({alu_pkg::result_width{sel_add}} & {alu_pkg::word_zero, sum_result})
                   | ({alu_pkg::result_width{sel_sub}} & {alu_pkg::word_zero, diff_result})
                   | ({alu_pkg::result_width{sel_uadd}} & uadd_result)
                   | ({alu_pkg::result_width{sel_mul}} & product)
                   | ({alu_pkg::result_width{sel_div}} & {remainder, quotient});
        end
    end

    // Z register pair
    always_ff @(posedge clock) begin
        if (reset) begin
            z_hi <= alu_pkg::word_zero;
            z_lo <= alu_pkg::word_zero;
        end else if (z_in) begin
            z_hi <= next_z[alu_pkg::result_width-1:alu_pkg::data_width];
            z_lo <= next_z[alu_pkg::data_width-1:0];
        end
    end

endmodule

/* logic/booth_multiplier.sv */
module booth_multiplier (
    input  logic [alu_pkg::data_width-1:0]   a,
    input  logic [alu_pkg::data_width-1:0]   b,
    output logic [alu_pkg::result_width-1:0] product
);

    // Multiplicand sign-extended to the full product width
    logic [alu_pkg::result_width-1:0] a_ext;

    // Multiplier with the implied zero below bit 0
    logic [alu_pkg::data_width:0] b_ext;

    // One partial product per Booth digit, already weighted
    logic [alu_pkg::result_width-1:0] partial [alu_pkg::booth_digits];

    assign a_ext = {{alu_pkg::data_width{a[alu_pkg::data_width-1]}}, a};
    assign b_ext = {b, 1'b0};

    for (genvar i = 0; i < alu_pkg::booth_digits; i++) begin : g_digit
        logic [2:0]                       triplet;
        logic [alu_pkg::result_width-1:0] multiple;

        // Overlapping bit triplet b[2i+1], b[2i], b[2i-1]
        assign triplet = b_ext[2*i +: 3];

        always_comb begin
            case (triplet)
                3'b001, 3'b010: begin
                    multiple = a_ext;         // Plus one
                end
                3'b011: begin
                    multiple = a_ext << 1;    // Plus two
                end
                3'b100: begin
                    multiple = -(a_ext << 1); // Minus two
                end
                3'b101, 3'b110: begin
                    multiple = -a_ext;        // Minus one
                end
                default: begin
                    multiple = '0;            // 000 and 111 add nothing
                end
            endcase
        end

        // Digit i carries weight 4 to the power i
        assign partial[i] = multiple << (2 * i);
    end

    // Modular 64-bit sum gives the signed product directly
    always_comb begin
        product = '0;
        for (int j = 0; j < alu_pkg::booth_digits; j++) begin
            product = product + partial[j];
        end
    end

endmodule

/* logic/restoring_divider.sv */
module restoring_divider (
    input  logic [alu_pkg::data_width-1:0] a,
    input  logic [alu_pkg::data_width-1:0] b,
    output logic [alu_pkg::data_width-1:0] quotient,
    output logic [alu_pkg::data_width-1:0] remainder
);

    logic                           a_neg;
    logic                           b_neg;
    logic [alu_pkg::data_width-1:0] a_mag;
    logic [alu_pkg::data_width-1:0] b_mag;
    logic [alu_pkg::data_width-1:0] quo_mag;
    logic [alu_pkg::data_width-1:0] rem_mag;
    logic [alu_pkg::data_width:0]   partial; // Shifted remainder, one bit wider
    logic [alu_pkg::data_width:0]   trial;

    assign a_neg = a[alu_pkg::data_width-1];
    assign b_neg = b[alu_pkg::data_width-1];

    // Magnitudes; the most negative value maps to 2^31 unsigned
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    // One restoring step per dividend bit, MSB first
    always_comb begin
        rem_mag = '0;
        quo_mag = '0;
        partial = '0;
        trial   = '0;
        for (int i = alu_pkg::data_width - 1; i >= 0; i--) begin
            partial = {rem_mag, a_mag[i]};
            trial   = partial - {1'b0, b_mag};
            if (!trial[alu_pkg::data_width]) begin
                rem_mag    = trial[alu_pkg::data_width-1:0]; // Subtract fits
                quo_mag[i] = 1'b1;
            end else begin
                rem_mag    = partial[alu_pkg::data_width-1:0]; // Restore
                quo_mag[i] = 1'b0;
            end
        end
    end

    // Truncate toward zero, remainder follows the dividend sign
    always_comb begin
        if (b == alu_pkg::word_zero) begin
            quotient  = '1;
            remainder = a;
        end else begin
            quotient  = (a_neg ^ b_neg) ? -quo_mag : quo_mag;
            remainder = a_neg ? -rem_mag : rem_mag;
        end
    end

endmodule

/* sources.f */
logic/alu_pkg.sv
logic/alu_logic_shift.sv
logic/booth_multiplier.sv
logic/restoring_divider.sv
logic/alu_arith.sv
logic/alu_result_select.sv
logic/alu.sv
bench/alu_props.sv
bench/alu_tb.sv
